// File: Bender.yml
package:
  name: st_bus_glue

sources:
  - include_dirs:
      - design
    files:
      - design/st_bus_pkg.sv
      - design/st_irq_pkg.sv
      - design/bus_slot_sequencer.sv
      - design/st_address_decoder.sv
      - design/cpu_bus_arbiter.sv
      - design/dtack_berr_unit.sv
      - design/interrupt_controller.sv
      - design/st_bus_glue.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/st_bus_glue_tb.sv

// File: compile.f
+incdir+design
design/st_bus_pkg.sv
design/st_irq_pkg.sv
design/bus_slot_sequencer.sv
design/st_address_decoder.sv
design/cpu_bus_arbiter.sv
design/dtack_berr_unit.sv
design/interrupt_controller.sv
design/st_bus_glue.sv
sim/st_bus_glue_tb.sv

// File: design/bus_slot_sequencer.sv
// bus slot sequencer
// four slot round video/cpu/io/spare, samples the cpu address strobe
`timescale 1ns/100ps
`include "st_settings.svh"

module bus_slot_sequencer (
	input  logic                  clk_8,
	input  logic                  pll_locked,
	input  logic                  cpu_as_n,
	input  logic                  bus_req,
	output st_bus_pkg::bus_slot_t bus_slot,
	output logic                  cpu_strobe
);
	import st_bus_pkg::*;

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			bus_slot   <= slot_video;
			cpu_strobe <= 1'b0;
		end else begin
			bus_slot <= bus_slot_t'(bus_slot + 2'd1);  // wraps spare -> video
			// taken at end of video slot, so only high in the cpu slot
			cpu_strobe <= (bus_slot == slot_video) && !cpu_as_n && !bus_req;
		end
	end

	a_slot_step: assert property (@(posedge clk_8) disable iff (!pll_locked)
		1'b1 |=> bus_slot == bus_slot_t'($past(bus_slot) + 2'd1));

	a_strobe_slot: assert property (@(posedge clk_8) disable iff (!pll_locked)
		cpu_strobe |-> bus_slot == slot_cpu);

endmodule

// File: design/cpu_bus_arbiter.sv
// st-ram arbiter
// shares ram between video and cpu slots, muxes cpu read data
`timescale 1ns/100ps
`include "st_settings.svh"

module cpu_bus_arbiter (
	input  st_bus_pkg::bus_slot_t  bus_slot,
	input  logic                   cpu_strobe,
	input  st_bus_pkg::word_addr_t cpu_addr,
	input  logic                   cpu_rw,
	input  logic                   cpu_uds_n,
	input  logic                   cpu_lds_n,
	input  logic                   mem_hit,
	input  logic                   ram_write_ok,
	input  st_bus_pkg::word_addr_t video_addr,
	input  logic                   video_read,
	input  st_bus_pkg::bus_data_t  ram_rdata,
	input  st_bus_pkg::bus_data_t  periph_rdata,
	input  st_irq_pkg::irq_vec_t   auto_vec,
	output st_bus_pkg::word_addr_t ram_addr,
	output logic                   ram_oe_n,
	output logic                   ram_we_n,
	output logic                   ram_uds_n,
	output logic                   ram_lds_n,
	output st_bus_pkg::bus_data_t  cpu_rdata
);
	import st_bus_pkg::*;

	always_comb begin
		ram_addr  = cpu_addr;
		ram_uds_n = cpu_uds_n;
		ram_lds_n = cpu_lds_n;
		ram_oe_n  = 1'b1;
		ram_we_n  = 1'b1;
		case (bus_slot)
			slot_video: begin
				ram_addr  = video_addr;
				ram_uds_n = 1'b0;           // video always fetches full words
				ram_lds_n = 1'b0;
				ram_oe_n  = !video_read;
			end
			slot_cpu: begin
				ram_oe_n = !(cpu_strobe && cpu_rw && mem_hit);
				ram_we_n = !(cpu_strobe && !cpu_rw && mem_hit && ram_write_ok);
			end
			default: ;                      // io and spare slots leave ram idle
		endcase
	end

	// vector only ever lands in the low byte
	assign cpu_rdata = mem_hit ? ram_rdata :
		(periph_rdata | {{(`ST_DATA_W-8){1'b0}}, auto_vec});

endmodule

// File: design/dtack_berr_unit.sv
// dtack and bus error unit
// dtack for decoded accesses, timeout to bus error, bus error count
`timescale 1ns/100ps
`include "st_settings.svh"

module dtack_berr_unit (
	input  logic                      clk_8,
	input  logic                      pll_locked,
	input  st_bus_pkg::bus_slot_t     bus_slot,
	input  logic                      cpu_strobe,
	input  logic                      cpu_as_n,
	input  logic                      bus_req,
	input  logic                      mem_hit,
	input  logic                      io_hit,
	input  logic                      cpu_clr_berr,
	output logic                      cpu_dtack_n,
	output logic                      cpu_berr,
	output logic [`ST_BERR_CNT_W-1:0] berr_count
);
	import st_bus_pkg::*;

	logic       dtack;
	logic [2:0] timeout;     // cpu slots without dtack
	logic       berr_d;

	assign dtack       = cpu_strobe && (mem_hit || io_hit) && !bus_req;
	assign cpu_dtack_n = !dtack;
	assign cpu_berr    = (timeout == 3'(`ST_BERR_LIMIT));

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			timeout <= '0;
		end else if (cpu_clr_berr) begin
			timeout <= '0;                  // exception taken, release berr
		end else if (!cpu_berr) begin
			if (bus_req)
				timeout <= '0;              // cpu just waits while halted
			else if (bus_slot == slot_cpu)
				timeout <= (cpu_as_n || dtack) ? 3'd0 : timeout + 3'd1;
		end
	end

	// debug count, one step per bus error
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			berr_d     <= 1'b0;
			berr_count <= '0;
		end else begin
			berr_d <= cpu_berr;
			if (cpu_berr && !berr_d)
				berr_count <= berr_count + 1'b1;
		end
	end

	a_dtack_berr: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!(dtack && cpu_berr));

	a_br_hold: assert property (@(posedge clk_8) disable iff (!pll_locked)
		(bus_req && !cpu_berr) |-> cpu_dtack_n ##1 (timeout == 3'd0));

endmodule

// File: design/interrupt_controller.sv
// interrupt controller
// vbi/hbi from sync edges, ipl priority encode, st autovectors
`timescale 1ns/100ps
`include "st_settings.svh"

module interrupt_controller (
	input  logic                 clk_8,
	input  logic                 pll_locked,
	input  logic                 vsync,
	input  logic                 hsync,
	input  logic                 mfp_irq,
	input  logic [2:0]           iack_level,
	output st_irq_pkg::ipl_t     cpu_ipl_n,
	output st_irq_pkg::irq_vec_t auto_vec
);
	import st_irq_pkg::*;

	// bit 0 is vsync/vbi, bit 1 hsync/hbi
	logic [1:0] sync_1, sync_2, sync_3;
	logic [1:0] pulse;
	logic [1:0] pend;
	logic [1:0] ack;
	ipl_t       ipl_next;

	assign ack = {iack_level == `ST_IACK_HBI, iack_level == `ST_IACK_VBI};

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync_1    <= '0;
			sync_2    <= '0;
			sync_3    <= '0;
			pulse     <= '0;
			pend      <= '0;
			cpu_ipl_n <= 3'b111;
		end else begin
			sync_1    <= {hsync, vsync};
			sync_2    <= sync_1;
			sync_3    <= sync_2;
			pulse     <= sync_2 & ~sync_3;   // rising edge, one cycle
			pend      <= (pend | pulse) & ~ack;  // ack wins over a new edge
			cpu_ipl_n <= ipl_next;
		end
	end

	// ipl[0] stays high, as on the real machine
	always_comb begin
		if (mfp_irq)
			ipl_next = 3'b001;   // level 6
		else if (pend[0])
			ipl_next = 3'b011;   // level 4
		else if (pend[1])
			ipl_next = 3'b101;   // level 2
		else
			ipl_next = 3'b111;
	end

	always_comb begin
		case (iack_level)
			`ST_IACK_VBI: auto_vec = `ST_VEC_VBI;
			`ST_IACK_HBI: auto_vec = `ST_VEC_HBI;
			default:      auto_vec = 8'h00;  // mfp gives its own vector
		endcase
	end

	a_ipl_legal: assert property (@(posedge clk_8) disable iff (!pll_locked)
		cpu_ipl_n inside {3'b001, 3'b011, 3'b101, 3'b111});

endmodule

// File: design/st_address_decoder.sv
// st address decoder
// memory map hits, io device select and irq ack level
`timescale 1ns/100ps
`include "st_settings.svh"

module st_address_decoder (
	input  st_bus_pkg::word_addr_t cpu_addr,
	input  logic                   cpu_rw,      // 1 = read
	input  logic                   cpu_strobe,
	input  st_bus_pkg::mem_cfg_t   mem_cfg,
	output logic                   mem_hit,
	output logic                   ram_write_ok,
	output logic                   io_hit,
	output st_bus_pkg::io_dev_t    periph_sel,
	output logic [2:0]             iack_level
);
	import st_bus_pkg::*;

	logic [`ST_ADDR_W:0] byte_addr;
	logic ram14, tos256, tos192, cart;
	logic io_page, iack_page, auto_iack;
	io_dev_t io_dev;

	assign byte_addr = {cpu_addr, 1'b0};

	// st-ram decode, anything below 0xe00000
	assign ram14  = (byte_addr[23:22] != 2'b11) || (byte_addr[23:21] == 3'b110);
	assign tos256 = (byte_addr[23:18] == 6'b111000);                  // e00000-e3ffff
	assign tos192 = (byte_addr[23:17] == 7'b1111110) ||
		(byte_addr[23:16] == 8'hfe);                                  // fc0000-feffff
	assign cart   = (byte_addr[23:17] == 7'b1111101);                 // fa0000-fbffff

	// rom and cartridge are read only
	assign mem_hit = ram14 || (cpu_rw && (tos256 || tos192 || cart));

	// writes only reach the fitted ram
	assign ram_write_ok = (byte_addr[23:22] == 2'b00) ||
		((byte_addr[23:22] == 2'b01) && ((mem_cfg == mem_8m) || (mem_cfg == mem_14m))) ||
		(((byte_addr[23:22] == 2'b10) || (byte_addr[23:21] == 3'b110)) &&
		 (mem_cfg == mem_14m));

	assign io_page   = (byte_addr[23:16] == `ST_IO_PAGE);
	assign iack_page = (byte_addr[23:4] == `ST_IACK_PAGE);
	assign auto_iack = iack_page &&
		((byte_addr[3:1] == `ST_IACK_VBI) || (byte_addr[3:1] == `ST_IACK_HBI));

	always_comb begin
		io_dev = dev_none;
		if (iack_page) begin
			if (byte_addr[3:1] == `ST_IACK_MFP)
				io_dev = dev_mfp_iack;       // mfp supplies its own vector
		end else if (io_page) begin
			if ({byte_addr[15:1], 1'b0} == `ST_MMU_BASE)
				io_dev = dev_mmu;
			else if ({byte_addr[15:7], 7'd0} == `ST_VREG_BASE)
				io_dev = dev_vreg;
			else if ({byte_addr[15:4], 4'd0} == `ST_DMA_BASE)
				io_dev = dev_dma;
			else if ({byte_addr[15:8], 8'd0} == `ST_PSG_BASE)
				io_dev = dev_psg;
			else if ({byte_addr[15:6], 6'd0} == `ST_MFP_BASE)
				io_dev = dev_mfp;
			else if ({byte_addr[15:8], 8'd0} == `ST_ACIA_BASE)
				io_dev = dev_acia;
		end
	end

	assign periph_sel = cpu_strobe ? io_dev : dev_none;
	assign io_hit     = cpu_strobe && ((io_dev != dev_none) || auto_iack);
	assign iack_level = (cpu_strobe && iack_page) ? byte_addr[3:1] : 3'd0;

endmodule

// File: design/st_bus_glue.sv
// st bus glue top
// slot sequencer, decoder, ram arbiter, dtack/berr and interrupts
`timescale 1ns/100ps
`include "st_settings.svh"

module st_bus_glue (
	input  logic                      clk_8,
	input  logic                      pll_locked,
	input  st_bus_pkg::word_addr_t    cpu_addr,
	input  logic                      cpu_rw,
	input  logic                      cpu_as_n,
	input  logic                      cpu_uds_n,
	input  logic                      cpu_lds_n,
	input  logic                      cpu_clr_berr,
	input  st_bus_pkg::mem_cfg_t      mem_cfg,
	input  logic                      bus_req,
	input  st_bus_pkg::word_addr_t    video_addr,
	input  logic                      video_read,
	input  logic                      vsync,
	input  logic                      hsync,
	input  st_bus_pkg::bus_data_t     ram_rdata,
	input  st_bus_pkg::bus_data_t     periph_rdata,   // or of all device reads
	input  logic                      mfp_irq,
	output logic                      cpu_dtack_n,
	output logic                      cpu_berr,
	output st_irq_pkg::ipl_t          cpu_ipl_n,
	output st_bus_pkg::bus_data_t     cpu_rdata,
	output st_bus_pkg::bus_slot_t     bus_slot,
	output st_bus_pkg::word_addr_t    ram_addr,
	output logic                      ram_oe_n,
	output logic                      ram_we_n,
	output logic                      ram_uds_n,
	output logic                      ram_lds_n,
	output st_bus_pkg::io_dev_t       periph_sel,
	output logic [`ST_BERR_CNT_W-1:0] berr_count
);
	import st_irq_pkg::*;

	logic       cpu_strobe;     // as_n sampled, high in cpu slot
	logic       mem_hit;
	logic       ram_write_ok;
	logic       io_hit;
	logic [2:0] iack_level;
	irq_vec_t   auto_vec;

	bus_slot_sequencer i_bus_slot_sequencer (
		.clk_8, .pll_locked, .cpu_as_n, .bus_req, .bus_slot, .cpu_strobe
	);

	st_address_decoder i_st_address_decoder (
		.cpu_addr, .cpu_rw, .cpu_strobe, .mem_cfg,
		.mem_hit, .ram_write_ok, .io_hit, .periph_sel, .iack_level
	);

	cpu_bus_arbiter i_cpu_bus_arbiter (
		.bus_slot, .cpu_strobe, .cpu_addr, .cpu_rw, .cpu_uds_n, .cpu_lds_n,
		.mem_hit, .ram_write_ok, .video_addr, .video_read, .ram_rdata,
		.periph_rdata, .auto_vec, .ram_addr, .ram_oe_n, .ram_we_n,
		.ram_uds_n, .ram_lds_n, .cpu_rdata
	);

	dtack_berr_unit i_dtack_berr_unit (
		.clk_8, .pll_locked, .bus_slot, .cpu_strobe, .cpu_as_n, .bus_req,
		.mem_hit, .io_hit, .cpu_clr_berr, .cpu_dtack_n, .cpu_berr, .berr_count
	);

	interrupt_controller i_interrupt_controller (
		.clk_8, .pll_locked, .vsync, .hsync, .mfp_irq, .iack_level,
		.cpu_ipl_n, .auto_vec
	);

endmodule

// File: design/st_bus_pkg.sv
// st bus types
// addresses, data words, bus slots, io selects and memory size codes
`include "st_settings.svh"

package st_bus_pkg;

	typedef logic [`ST_ADDR_W-1:0] word_addr_t;  // byte address bits 23..1
	typedef logic [`ST_DATA_W-1:0] bus_data_t;

	// one slot per clk_8 cycle, four per round
	typedef enum logic [1:0] {
		slot_video = 2'd0,
		slot_cpu   = 2'd1,
		slot_io    = 2'd2,
		slot_spare = 2'd3
	} bus_slot_t;

	// encoded select for the peripheral side
	typedef enum logic [2:0] {
		dev_none, dev_mmu, dev_vreg, dev_mfp,
		dev_acia, dev_psg, dev_dma, dev_mfp_iack
	} io_dev_t;

	// same codes as the old memory size field
	typedef enum logic [2:0] {
		mem_512k = 3'd0,
		mem_1m   = 3'd1,
		mem_2m   = 3'd2,
		mem_4m   = 3'd3,
		mem_8m   = 3'd4,
		mem_14m  = 3'd5
	} mem_cfg_t;

endpackage

// File: design/st_irq_pkg.sv
// st interrupt types
// 68000 priority level and vector byte

package st_irq_pkg;

	// ipl lines as seen by the cpu, active low
	// 111 idle, 101 hbi, 011 vbi, 001 mfp
	typedef logic [2:0] ipl_t;

	// vector number returned in the low byte of an ack cycle
	typedef logic [7:0] irq_vec_t;

endpackage

// File: design/st_settings.svh
// st bus glue settings
// widths, bus error timeout, autovector bytes and memory map codes
`ifndef ST_SETTINGS_SVH
`define ST_SETTINGS_SVH

`define ST_ADDR_W      23         // word address, byte address bits 23..1
`define ST_DATA_W      16
`define ST_BERR_CNT_W  4

// cpu slots without dtack before bus error
`define ST_BERR_LIMIT  7

// vectors for the levels the st autovectors
`define ST_VEC_VBI     8'h1c
`define ST_VEC_HBI     8'h1a

// io page and irq ack page, upper byte address bits
`define ST_IO_PAGE     8'hff      // bits 23..16
`define ST_IACK_PAGE   20'hfffff  // bits 23..4
`define ST_IACK_HBI    3'd2
`define ST_IACK_VBI    3'd4
`define ST_IACK_MFP    3'd6

// device bases inside the io page, low 16 bits
`define ST_MMU_BASE    16'h8000
`define ST_VREG_BASE   16'h8200
`define ST_DMA_BASE    16'h8600
`define ST_PSG_BASE    16'h8800
`define ST_MFP_BASE    16'hfa00
`define ST_ACIA_BASE   16'hfc00

`endif

// File: sim/st_bus_glue_tb.sv
// testbench for the st bus glue
// ram, rom, io decode, bus request and interrupt cycles against a reference map
`timescale 1ns/100ps
`include "st_settings.svh"

module st_bus_glue_tb;
	import st_bus_pkg::*;
	import st_irq_pkg::*;

	localparam int ACCESS_COUNT = 36;
	localparam int CYCLE_LIMIT  = ACCESS_COUNT * 40 + 200;

	logic clk_8 = 1'b0;
	logic pll_locked, cpu_rw, cpu_as_n, cpu_uds_n, cpu_lds_n, cpu_clr_berr;
	logic bus_req, video_read, vsync, hsync, mfp_irq;
	logic cpu_dtack_n, cpu_berr, ram_oe_n, ram_we_n, ram_uds_n, ram_lds_n;
	word_addr_t cpu_addr, video_addr, ram_addr;
	mem_cfg_t mem_cfg;
	bus_data_t ram_rdata, periph_rdata, cpu_rdata;
	bus_slot_t bus_slot;
	io_dev_t periph_sel;
	ipl_t cpu_ipl_n;
	logic [`ST_BERR_CNT_W-1:0] berr_count;

	// expected outcome of the access in flight
	bit armed = 1'b0, count_wait = 1'b0, acc_done = 1'b0;
	logic exp_berr, exp_rw, exp_oe_n, exp_we_n;
	logic [1:0] exp_lanes;   // uds_n, lds_n
	word_addr_t exp_addr;
	io_dev_t exp_sel;
	bus_data_t exp_rdata;
	logic [`ST_BERR_CNT_W-1:0] exp_count;   // bus errors the map predicts so far

	int seed = 32'hed58_2fe7;
	int errors = 0, checks = 0, tests = 0, test_errors = 0, test_checks = 0;
	int cycles;

	st_bus_glue i_st_bus_glue (.*);

	initial forever #50 clk_8 = ~clk_8;   // 100 ns

	// video fetch stream with a new address every cycle
	always @(posedge clk_8) begin
		#10;
		if (pll_locked) begin
			video_addr = video_addr + 23'h0000a3;
			video_read = video_addr[1];
		end
	end

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		test_checks++;
		assert (expected === actual) else begin
			errors++;
			test_errors++;
			$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	task automatic report_problem(input string msg);
		errors++;
		test_errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %-10s %0d checks, %0d errors", name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// memory map model for ram, rom, cartridge, io page and ack page
	function automatic void predict_access(input logic [23:0] ba, input logic rw,
		input mem_cfg_t cfg, output logic hit, output logic wr_ok,
		output io_dev_t dev, output logic [7:0] vec);
		logic rom;
		rom = (ba >= 24'he00000 && ba <= 24'he3ffff) ||   // tos 256k
			(ba >= 24'hfc0000 && ba <= 24'hfeffff) ||     // tos 192k
			(ba >= 24'hfa0000 && ba <= 24'hfbffff);       // cartridge
		hit = (ba < 24'he00000) || (rw && rom);
		wr_ok = (ba < 24'h400000) ||
			(ba < 24'h800000 && (cfg == mem_8m || cfg == mem_14m)) ||
			(ba < 24'he00000 && cfg == mem_14m);
		dev = dev_none;
		vec = 8'h00;
		if (ba >= 24'hfffff0) begin
			case (ba[3:1])
				3'd6: dev = dev_mfp_iack;
				3'd4: vec = `ST_VEC_VBI;
				3'd2: vec = `ST_VEC_HBI;
				default: ;
			endcase
		end else if (ba >= 24'hff8000 && ba <= 24'hff8001) dev = dev_mmu;
		else if (ba >= 24'hff8200 && ba <= 24'hff827f) dev = dev_vreg;
		else if (ba >= 24'hff8600 && ba <= 24'hff860f) dev = dev_dma;
		else if (ba >= 24'hff8800 && ba <= 24'hff88ff) dev = dev_psg;
		else if (ba >= 24'hfffa00 && ba <= 24'hfffa3f) dev = dev_mfp;
		else if (ba >= 24'hfffc00 && ba <= 24'hfffcff) dev = dev_acia;
	endfunction

	// one 68000 cycle with bus_req held high for hold cycles first
	task automatic cpu_access(input logic [23:0] ba, input logic rw, input int hold);
		logic hit, wr_ok;
		io_dev_t dev;
		logic [7:0] vec;
		logic [`ST_BERR_CNT_W-1:0] count_before;
		int lane_r;
		@(posedge clk_8);
		#10;
		ram_rdata = $random(seed);
		periph_rdata = $random(seed);
		lane_r = $random(seed);
		if (ba >= 24'hfffff0)
			periph_rdata[7:0] = 8'h00;   // low byte of an ack cycle carries only the vector
		predict_access(ba, rw, mem_cfg, hit, wr_ok, dev, vec);
		exp_berr = !(hit || dev != dev_none || vec != 8'h00);
		exp_rw = rw;
		exp_addr = ba[23:1];
		exp_lanes = (lane_r[1:0] == 2'b11) ? 2'b00 : lane_r[1:0];   // word or one byte
		exp_oe_n = !(rw && hit);
		exp_we_n = !(!rw && hit && wr_ok);
		exp_sel = dev;
		exp_rdata = hit ? ram_rdata : (periph_rdata | {8'h00, vec});
		count_before = exp_count;
		if (exp_berr)
			exp_count = exp_count + 1'b1;
		acc_done = 1'b0;
		armed = 1'b1;
		cpu_addr = ba[23:1];
		cpu_rw = rw;
		{cpu_uds_n, cpu_lds_n} = exp_lanes;
		bus_req = (hold > 0);
		cpu_as_n = 1'b0;
		if (hold > 0) begin
			repeat (hold) @(posedge clk_8);
			#10;
			compare_value("berr_count", count_before, berr_count);
			bus_req = 1'b0;
		end
		wait (acc_done);
		@(posedge clk_8);
		#10;
		cpu_as_n = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		if (exp_berr) begin
			cpu_clr_berr = 1'b1;   // exception handler entered
			@(posedge clk_8);
			#10;
			cpu_clr_berr = 1'b0;
		end
	endtask

	task automatic wait_ipl(input ipl_t expected, input int max_cycles);
		int n;
		n = 0;
		while (cpu_ipl_n !== expected && n < max_cycles) begin
			@(negedge clk_8);
			n++;
		end
		compare_value("cpu_ipl_n", expected, cpu_ipl_n);
		@(posedge clk_8);
		#10;   // back on the drive point after a rising edge
	endtask

	// comparator at mid cycle where every output has settled
	always @(negedge clk_8) begin
		if (pll_locked && bus_slot == slot_video) begin
			compare_value("ram_addr", video_addr, ram_addr);
			compare_value("ram_oe_n", !video_read, ram_oe_n);
			compare_value("ram_uds_n/lds_n", 2'b00, {ram_uds_n, ram_lds_n});
		end
		if (armed && bus_req) begin
			assert (cpu_dtack_n && !cpu_berr)
				else report_problem("access ended while bus_req was high");
		end else if (armed && count_wait) begin
			compare_value("berr_count", exp_count, berr_count);   // one cycle behind berr
			count_wait = 1'b0;
			armed = 1'b0;
			acc_done = 1'b1;
		end else if (armed && (!cpu_dtack_n || cpu_berr)) begin
			compare_value("cpu_berr", exp_berr, cpu_berr);
			if (cpu_berr) begin
				count_wait = 1'b1;
			end else begin
				compare_value("bus_slot", slot_cpu, bus_slot);
				compare_value("ram_addr", exp_addr, ram_addr);
				compare_value("ram_uds_n/lds_n", exp_lanes, {ram_uds_n, ram_lds_n});
				compare_value("ram_oe_n", exp_oe_n, ram_oe_n);
				compare_value("ram_we_n", exp_we_n, ram_we_n);
				compare_value("periph_sel", exp_sel, periph_sel);
				compare_value("berr_count", exp_count, berr_count);
				if (exp_rw)
					compare_value("cpu_rdata", exp_rdata, cpu_rdata);
				armed = 1'b0;
				acc_done = 1'b1;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_8);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		int r;
		pll_locked = 1'b0;
		{cpu_rw, cpu_as_n, cpu_uds_n, cpu_lds_n} = 4'b1111;
		{cpu_clr_berr, bus_req, video_read, vsync, hsync, mfp_irq} = 6'b0;
		cpu_addr = '0;
		video_addr = '0;
		mem_cfg = mem_4m;
		ram_rdata = '0;
		periph_rdata = '0;
		exp_count = '0;
		repeat (2) @(posedge clk_8);
		@(negedge clk_8);
		compare_value("bus_slot", slot_video, bus_slot);
		compare_value("cpu_dtack_n", 1'b1, cpu_dtack_n);
		compare_value("cpu_berr", 1'b0, cpu_berr);
		compare_value("ram_oe_n/we_n", 2'b11, {ram_oe_n, ram_we_n});
		compare_value("cpu_ipl_n", 3'b111, cpu_ipl_n);
		compare_value("berr_count", 0, berr_count);
		@(posedge clk_8);
		#10 pll_locked = 1'b1;   // released after 3 cycles
		end_test("reset");

		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			cpu_access({2'b00, r[21:1], 1'b0}, r[31], 0);   // below 4 MB
		end
		end_test("st_ram");

		cpu_access(24'h500000, 1'b0, 0);   // above the fitted 4 MB so the write is dropped
		mem_cfg = mem_8m;
		cpu_access(24'h600000, 1'b0, 0);
		cpu_access(24'h900000, 1'b0, 0);
		cpu_access(24'he00100, 1'b0, 0);   // rom and cart writes fault
		cpu_access(24'hfc0200, 1'b0, 0);
		cpu_access(24'hfa0040, 1'b0, 0);
		cpu_access(24'he00100, 1'b1, 0);
		cpu_access(24'hfc0200, 1'b1, 0);
		cpu_access(24'hfa0040, 1'b1, 0);
		end_test("mem_rom");

		cpu_access(24'hff8000, 1'b1, 0);
		cpu_access(24'hff8240, 1'b1, 0);
		cpu_access(24'hff8604, 1'b1, 0);
		cpu_access(24'hff8800, 1'b1, 0);
		cpu_access(24'hfffa10, 1'b1, 0);
		cpu_access(24'hfffc02, 1'b1, 0);
		cpu_access(24'hff9000, 1'b1, 0);   // unmapped
		end_test("io_decode");

		cpu_access(24'h012340, 1'b1, 40);
		end_test("bus_req");

		@(posedge clk_8);
		#10 vsync = 1'b1;
		wait_ipl(3'b011, 8);
		vsync = 1'b0;
		cpu_access(24'hfffff8, 1'b1, 0);   // level 4 ack
		wait_ipl(3'b111, 4);
		hsync = 1'b1;
		wait_ipl(3'b101, 8);
		hsync = 1'b0;
		cpu_access(24'hfffff4, 1'b1, 0);   // level 2 ack
		wait_ipl(3'b111, 4);
		mfp_irq = 1'b1;
		wait_ipl(3'b001, 4);
		cpu_access(24'hfffffc, 1'b1, 0);   // level 6 ack with the mfp vector
		mfp_irq = 1'b0;
		wait_ipl(3'b111, 4);
		end_test("interrupts");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
